// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_phy_endpoint_rx
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
source/phy_types_pkg.sv
source/phy_rx_sampler.sv
source/phy_rx_fsm.sv
source/phy_flit_assembler.sv
source/phy_endpoint_rx.sv
testbench/tb_phy_endpoint_rx.sv

// File: source/phy_endpoint_rx.sv
`timescale 1ns/1ps
`default_nettype none

module phy_endpoint_rx (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  serial_in,
    output phy_types_pkg::flit_t  flit,
    output logic                  flit_valid,
    output logic                  link_err
);
    import phy_types_pkg::*;

    logic       line;
    logic       fall;
    logic       bit_tick;
    logic       timer_en;
    logic       done;
    logic       rx_err;
    rx_result_t result;

    phy_rx_sampler phy_rx_sampler_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .serial_in (serial_in),
        .timer_en  (timer_en),
        .line      (line),
        .fall      (fall),
        .bit_tick  (bit_tick)
    );

    phy_rx_fsm phy_rx_fsm_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .line     (line),
        .fall     (fall),
        .bit_tick (bit_tick),
        .timer_en (timer_en),
        .done     (done),
        .rx_err   (rx_err),
        .result   (result)
    );

    phy_flit_assembler phy_flit_assembler_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .done       (done),
        .rx_err     (rx_err),
        .result     (result),
        .flit       (flit),
        .flit_valid (flit_valid),
        .link_err   (link_err)
    );

endmodule

`default_nettype wire

// File: source/phy_flit_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module phy_flit_assembler (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       done,
    input  logic                       rx_err,
    input  phy_types_pkg::rx_result_t  result,
    output phy_types_pkg::flit_t       flit,
    output logic                       flit_valid,
    output logic                       link_err
);
    import phy_types_pkg::*;

    logic [1:0]  flits_left;
    logic [1:0]  byte_idx;
    logic [23:0] acc;
    logic        grp_open;
    logic        is_comma;

    assign grp_open = (flits_left != 2'd0);
    assign is_comma = (result.comma_sel != NADA);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flits_left <= 2'd0;
            byte_idx   <= 2'd0;
            flit_valid <= 1'b0;
            link_err   <= 1'b0;
        end else begin
            flit_valid <= 1'b0;
            link_err   <= 1'b0;
            if (rx_err) begin
                link_err   <= 1'b1;
                flits_left <= 2'd0;
            end else if (done && is_comma) begin
                // A comma mid-group is an error but still starts a fresh group
                link_err   <= grp_open;
                flits_left <= (result.comma_sel == SELECT_COMMA_2_FLIT) ? 2'd2 : 2'd1;
                byte_idx   <= 2'd0;
            end else if (done) begin
                if (!grp_open) begin
                    link_err <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx == 2'd3) begin
                        flit_valid <= 1'b1;
                        flits_left <= flits_left - 2'd1;
                    end
                end
            end
        end
    end

    // Byte lanes fill LSB first
    always_ff @(posedge CLK) begin
        if (done && !is_comma && grp_open) begin
            if (byte_idx == 2'd3) begin
                flit.payload <= {result.data, acc};
                flit.last    <= (flits_left == 2'd1);
            end else begin
                acc[{byte_idx, 3'b000} +: 8] <= result.data;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) flit_valid |-> $past(grp_open))
        else $error("flit emitted with no group open");

endmodule

`default_nettype wire

// File: source/phy_rx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module phy_rx_fsm (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     line,
    input  logic                     fall,
    input  logic                     bit_tick,
    output logic                     timer_en,
    output logic                     done,
    output logic                     rx_err,
    output phy_types_pkg::rx_result_t result
);
    import phy_types_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        START,
        RECEIVE,
        DONE,
        ERROR
    } rx_state_t;

    rx_state_t   state;
    rx_state_t   next_state;
    logic [3:0]  bit_cnt;
    logic [7:0]  shreg;
    frame_kind_t kind_q;
    frame_kind_t kind_now;
    logic        is_stop;
    logic        shift_en;

    // Kind bits arrive LSB first, so bit 0 sits at the top of the shift register
    assign kind_now = frame_kind_t'({line, shreg[7]});

    // Stop bit follows 2 kind bits, plus 8 payload bits for data
    assign is_stop = (bit_cnt == 4'd2 && kind_q != KIND_DATA) ||
                     (bit_cnt == 4'd10 && kind_q == KIND_DATA);

    assign shift_en = (state == RECEIVE) && bit_tick && !is_stop;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (fall) begin
                    next_state = START;
                end
            end
            START: begin
                if (bit_tick) begin
                    next_state = line ? ERROR : RECEIVE;
                end
            end
            RECEIVE: begin
                if (bit_tick) begin
                    if (bit_cnt == 4'd1 && kind_now == KIND_INVALID) begin
                        next_state = ERROR;
                    end else if (is_stop) begin
                        next_state = line ? DONE : ERROR;
                    end
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            ERROR: begin
                // Wait for the line to settle high before hunting again
                if (bit_tick && line) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            rx_err  <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else begin
            state  <= next_state;
            rx_err <= (next_state == ERROR) && (state != ERROR);
            if (state != RECEIVE) begin
                bit_cnt <= '0;
            end else if (bit_tick) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            if (shift_en) begin
                shreg <= {line, shreg[7:1]};
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (shift_en && bit_cnt == 4'd1) begin
            kind_q <= kind_now;
        end
    end

    assign timer_en = (state == START) || (state == RECEIVE) || (state == ERROR);
    assign done     = (state == DONE);

    always_comb begin
        result.data = shreg;
        case (kind_q)
            KIND_COMMA_1: result.comma_sel = SELECT_COMMA_1_FLIT;
            KIND_COMMA_2: result.comma_sel = SELECT_COMMA_2_FLIT;
            default:      result.comma_sel = NADA;
        endcase
        if (state != DONE) begin
            result.comma_sel = NADA;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        (shreg != $past(shreg)) |-> ($past(state) == RECEIVE))
        else $error("shift register moved outside RECEIVE");

    assert property (@(posedge CLK) disable iff (!nRST) !(done && rx_err))
        else $error("done and rx_err together");

endmodule

`default_nettype wire

// File: source/phy_rx_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module phy_rx_sampler (
    input  logic CLK,
    input  logic nRST,
    input  logic serial_in,
    input  logic timer_en,
    output logic line,
    output logic fall,
    output logic bit_tick
);
    import phy_types_pkg::*;

    localparam int CNT_W     = $clog2(CLKDIV_COUNT);
    localparam int HALF_BIT  = CLKDIV_COUNT / 2;

    logic             sync_q1;
    logic             sync_q2;
    logic             line_q;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_last;
    logic             first_half;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
            line_q  <= 1'b1;
        end else begin
            sync_q1 <= serial_in;
            sync_q2 <= sync_q1;
            line_q  <= sync_q2;
        end
    end

    assign line = sync_q2;
    assign fall = line_q & ~sync_q2;

    // First period is half a bit to land on mid-bit
    assign count_last = first_half ? CNT_W'(HALF_BIT - 1) : CNT_W'(CLKDIV_COUNT - 1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count      <= '0;
            first_half <= 1'b1;
            bit_tick   <= 1'b0;
        end else if (!timer_en) begin
            count      <= '0;
            first_half <= 1'b1;
            bit_tick   <= 1'b0;
        end else if (count == count_last) begin
            count      <= '0;
            first_half <= 1'b0;
            bit_tick   <= 1'b1;
        end else begin
            count    <= count + 1'b1;
            bit_tick <= 1'b0;
        end
    end

    // The state machine must not drop timer_en right as a tick is issued
    assert property (@(posedge CLK) disable iff (!nRST) !timer_en |-> !bit_tick)
        else $error("bit_tick while timer disabled");

endmodule

`default_nettype wire

// File: source/phy_types_pkg.sv
`default_nettype none

package phy_types_pkg;

    // Clocks per bit on the serial line
    localparam int CLKDIV_COUNT = 8;

    // Frame kind field, received LSB first after the start bit
    typedef enum logic [1:0] {
        KIND_COMMA_1 = 2'b00,
        KIND_COMMA_2 = 2'b01,
        KIND_DATA    = 2'b10,
        KIND_INVALID = 2'b11
    } frame_kind_t;

    // Comma decode handed to the flit assembler
    typedef enum logic [1:0] {
        NADA                = 2'b00,
        SELECT_COMMA_1_FLIT = 2'b01,
        SELECT_COMMA_2_FLIT = 2'b10
    } comma_sel_t;

    // One decoded frame, qualified by done
    typedef struct packed {
        comma_sel_t comma_sel;
        logic [7:0] data;
    } rx_result_t;

    // Assembled flit, qualified by flit_valid
    typedef struct packed {
        logic [31:0] payload;
        logic        last;
    } flit_t;

endpackage

`default_nettype wire

// File: testbench/tb_phy_endpoint_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phy_endpoint_rx;
    import phy_types_pkg::*;

    // Frames sent by all tests together, glitch included
    localparam int FRAME_COUNT   = 37;
    localparam int CYCLE_LIMIT   = FRAME_COUNT * 14 * CLKDIV_COUNT + 1000;
    localparam int WAIT_LIMIT    = 4 * 14 * CLKDIV_COUNT;
    localparam int GLITCH_CYCLES = 2;

    logic  CLK;
    logic  nRST;
    logic  serial_in;
    flit_t flit;
    logic  flit_valid;
    logic  link_err;

    flit_t       exp_flits[$];
    flit_t       mon_exp;
    int          errs_expected;
    int          errs_seen;
    int          cycles;
    string       cur_test;
    logic [31:0] lfsr;

    phy_endpoint_rx phy_endpoint_rx_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .serial_in  (serial_in),
        .flit       (flit),
        .flit_valid (flit_valid),
        .link_err   (link_err)
    );

    always #20 CLK = ~CLK;

    task automatic stop_on_error();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles during test %s", CYCLE_LIMIT, cur_test);
            stop_on_error();
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        lfsr_next = {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic check_flit(input string test, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected flit payload %h last %b, actual payload %h last %b",
                     test, exp.payload, exp.last, act.payload, act.last);
            stop_on_error();
        end
    endtask

    task automatic check_err(input string test, input int exp_count);
        int waited;
        waited = 0;
        while (errs_seen < exp_count && waited < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (errs_seen != exp_count) begin
            $display("[FAIL] %s: expected %0d link_err pulses, actual %0d",
                     test, exp_count, errs_seen);
            stop_on_error();
        end
    endtask

    task automatic wait_flits(input string test);
        int waited;
        waited = 0;
        while (exp_flits.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (exp_flits.size() != 0) begin
            $display("[FAIL] %s: expected 0 pending flits, actual %0d",
                     test, exp_flits.size());
            stop_on_error();
        end
    endtask

    // Flits and errors are matched on the falling edge, away from DUT updates
    always @(negedge CLK) begin
        if (nRST && flit_valid) begin
            if (exp_flits.size() == 0) begin
                $display("Unexpected flit %h during test %s", flit, cur_test);
                stop_on_error();
            end else begin
                mon_exp = exp_flits.pop_front();
                check_flit(cur_test, mon_exp, flit);
            end
        end
        if (nRST && link_err) begin
            errs_seen = errs_seen + 1;
            if (errs_seen > errs_expected) begin
                $display("Unexpected link_err during test %s", cur_test);
                stop_on_error();
            end
        end
    end

    task automatic drive_bit(input logic b);
        serial_in = b;
        repeat (CLKDIV_COUNT) @(posedge CLK);
        #1;
    endtask

    task automatic send_frame(input frame_kind_t kind, input logic [7:0] data,
                              input logic bad_stop, input logic glitch);
        int i;
        if (glitch) begin
            serial_in = 1'b0;
            repeat (GLITCH_CYCLES) @(posedge CLK);
            #1;
            repeat (3) drive_bit(1'b1);
        end else begin
            drive_bit(1'b0);
            drive_bit(kind[0]);
            drive_bit(kind[1]);
            if (kind == KIND_DATA) begin
                for (i = 0; i < 8; i++) begin
                    drive_bit(data[i]);
                end
            end
            drive_bit(!bad_stop);
            // One idle bit between frames
            drive_bit(1'b1);
        end
    endtask

    task automatic send_flit_bytes(input logic last);
        logic [7:0] b [4];
        flit_t      exp;
        int         i;
        for (i = 0; i < 4; i++) begin
            random_byte(b[i]);
        end
        exp.payload = {b[3], b[2], b[1], b[0]};
        exp.last    = last;
        exp_flits.push_back(exp);
        for (i = 0; i < 4; i++) begin
            send_frame(KIND_DATA, b[i], 1'b0, 1'b0);
        end
    endtask

    task automatic finish_test();
        check_err(cur_test, errs_expected);
        wait_flits(cur_test);
        repeat (2 * CLKDIV_COUNT) @(posedge CLK);
        #1;
    endtask

    task automatic test_comma1_flit();
        cur_test = "comma1_flit";
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b0);
        send_flit_bytes(1'b1);
        finish_test();
    endtask

    task automatic test_comma2_flits();
        cur_test = "comma2_flits";
        send_frame(KIND_COMMA_2, 8'h00, 1'b0, 1'b0);
        send_flit_bytes(1'b0);
        send_flit_bytes(1'b1);
        finish_test();
    endtask

    task automatic test_bad_frames();
        logic [7:0] b;
        cur_test = "bad_frames";
        random_byte(b);
        // A missed framing error would land in the open group without link_err
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b0);
        errs_expected++;
        send_frame(KIND_DATA, b, 1'b1, 1'b0);
        check_err(cur_test, errs_expected);
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b0);
        errs_expected++;
        send_frame(KIND_INVALID, 8'h00, 1'b0, 1'b0);
        finish_test();
    endtask

    task automatic test_start_glitch();
        cur_test = "start_glitch";
        errs_expected++;
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b1);
        check_err(cur_test, errs_expected);
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b0);
        send_flit_bytes(1'b1);
        finish_test();
    endtask

    task automatic test_orphan_data();
        logic [7:0] b;
        cur_test = "orphan_data";
        random_byte(b);
        errs_expected++;
        send_frame(KIND_DATA, b, 1'b0, 1'b0);
        finish_test();
    endtask

    task automatic test_comma_interrupt();
        logic [7:0] b;
        int         i;
        cur_test = "comma_interrupt";
        send_frame(KIND_COMMA_1, 8'h00, 1'b0, 1'b0);
        for (i = 0; i < 2; i++) begin
            random_byte(b);
            send_frame(KIND_DATA, b, 1'b0, 1'b0);
        end
        // The new comma is flagged but opens its own group
        errs_expected++;
        send_frame(KIND_COMMA_2, 8'h00, 1'b0, 1'b0);
        send_flit_bytes(1'b0);
        send_flit_bytes(1'b1);
        finish_test();
    endtask

    initial begin
        CLK           = 1'b0;
        nRST          = 1'b0;
        serial_in     = 1'b1;
        errs_expected = 0;
        errs_seen     = 0;
        cycles        = 0;
        lfsr          = 32'h7b3c;
        cur_test      = "reset";
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        repeat (2 * CLKDIV_COUNT) @(posedge CLK);
        #1;

        test_comma1_flit();
        test_comma2_flits();
        test_bad_frames();
        test_start_glitch();
        test_orphan_data();
        test_comma_interrupt();

        if (exp_flits.size() != 0 || errs_seen != errs_expected) begin
            $display("Flit or error counts do not match at the end of the run");
            stop_on_error();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
